// File: clk_ctrl_pkg.sv
package clk_ctrl_pkg;

	// --------------------
	// Comparator clock phase
	// --------------------

	// Code from the slow-control register
	localparam int CMP_CODE_W          = 5;
	localparam int CMP_TABLE_SIZE      = 32;
	// One 25 ns period at 1/56 of the 960 MHz VCO period
	localparam int CMP_STEPS_PER_CYCLE = 1344;
	// Holds 0 to 1344
	localparam int PHASE_W             = 11;

	// --------------------
	// Sampling clock and resync
	// --------------------

	localparam int SAMP_CODE_W  = 3;
	// Sampling PLL reset length in CLK40 cycles
	localparam int RST_PIPE_LEN = 8;
	// 40 MHz down to the 1 us tick
	localparam int TICK_DIV     = 40;
	localparam int TICK_W       = 6;
	// Resync holdoff, in ticks
	localparam int HOLDOFF_US   = 100;
	localparam int HOLDOFF_W    = 8;

	// Phase shift sequencer states
	typedef enum logic [2:0]
	{
		ST_IDLE      = 3'd0,
		ST_WAIT_LOCK = 3'd1,
		ST_PULSE     = 3'd2,
		ST_WAIT_DONE = 3'd3,
		ST_ACK       = 3'd4
	} phs_state_t;

	// Code i to fine step, i*1344/31 rounded to nearest
	// Code 31 lands on a full period
	function automatic logic [PHASE_W-1:0] cmp_phase_of(input logic [CMP_CODE_W-1:0] code);
		int unsigned num;
		num = int'(code) * CMP_STEPS_PER_CYCLE * 2 + (CMP_TABLE_SIZE - 1);
		return PHASE_W'(num / (2 * (CMP_TABLE_SIZE - 1)));
	endfunction

endpackage

// File: resync_ctrl.sv
`timescale 1ns/1ps

module resync_ctrl
(
	input  logic                                CLK40,
	input  logic                                RST,
	input  logic                                resync,
	input  logic                                samp_clk_phs_chng,
	input  logic [clk_ctrl_pkg::SAMP_CODE_W-1:0] samp_clk_phase,
	output logic                                lead_edge_resync,
	output logic                                cap_phase,
	output logic                                samp_mmcm_rst,
	output logic                                samp_in_sel,
	output logic                                dsr_resync
);

	import clk_ctrl_pkg::*;

	logic                    resync_d1;
	logic                    lead_edge_d1;
	// Reset release delay, preset high
	logic                    rst_d1;
	logic                    rst_d2;
	logic                    trl_edge_rst;
	logic [RST_PIPE_LEN-1:0] rst_pipe;
	logic                    clk20_phase;
	logic                    c20_phase_sel;
	logic [TICK_W-1:0]       tick_cnt;
	logic                    tick;
	logic [HOLDOFF_W-1:0]    ho_tmr;
	logic                    clr_ho;

	// --------------------
	// Edge detection
	// --------------------

	// One cycle per resync rise
	assign lead_edge_resync = resync & ~resync_d1;
	// Two cycles wide after reset falls
	assign trl_edge_rst = ~RST & rst_d2;

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			resync_d1    <= 1'b0;
			lead_edge_d1 <= 1'b0;
			rst_d1       <= 1'b1;
			rst_d2       <= 1'b1;
			cap_phase    <= 1'b0;
			rst_pipe     <= '0;
		end
		else
		begin
			resync_d1    <= resync;
			lead_edge_d1 <= lead_edge_resync;
			rst_d1       <= 1'b0;
			rst_d2       <= rst_d1;
			// Capture strobe, held two cycles on resync
			cap_phase    <= lead_edge_resync | lead_edge_d1 | trl_edge_rst | samp_clk_phs_chng;
			rst_pipe     <= {rst_pipe[RST_PIPE_LEN-2:0], cap_phase};
		end
	end

	// Sampling PLL held in reset across the capture
	assign samp_mmcm_rst = |rst_pipe;

	// --------------------
	// 20 MHz half phase
	// --------------------

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			clk20_phase   <= 1'b0;
			c20_phase_sel <= 1'b0;
		end
		else
		begin
			// Realigned to the resync edge
			if (lead_edge_resync)
				clk20_phase <= 1'b0;
			else
				clk20_phase <= ~clk20_phase;
			if (cap_phase)
				c20_phase_sel <= clk20_phase;
		end
	end

	// Top code bit flips the 20 MHz input
	assign samp_in_sel = samp_clk_phase[2] ^ c20_phase_sel;

	// --------------------
	// Holdoff timer
	// --------------------

	assign tick   = (tick_cnt == TICK_W'(TICK_DIV - 1));
	assign clr_ho = (ho_tmr == HOLDOFF_W'(HOLDOFF_US));

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			tick_cnt   <= '0;
			ho_tmr     <= '0;
			dsr_resync <= 1'b0;
		end
		else
		begin
			// Free running 1 us divider
			if (tick)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
			// New capture restarts the holdoff
			if (cap_phase)
				dsr_resync <= 1'b1;
			else if (clr_ho)
				dsr_resync <= 1'b0;
			if (cap_phase || !dsr_resync)
				ho_tmr <= '0;
			else if (tick)
				ho_tmr <= ho_tmr + 1'b1;
		end
	end

endmodule

// File: cmp_phase_tracker.sv
`timescale 1ns/1ps

module cmp_phase_tracker
(
	input  logic                               CLK40,
	input  logic                               RST,
	input  logic                               cmp_phs_jtag_rst,
	input  logic [clk_ctrl_pkg::CMP_CODE_W-1:0] cmp_clk_phase,
	input  logic                               step_ack,
	output logic                               cmp_phs_rst,
	output logic [clk_ctrl_pkg::PHASE_W-1:0]    cmp_phase_target,
	output logic [clk_ctrl_pkg::PHASE_W-1:0]    cmp_phase_cur,
	output logic                               step_req,
	output logic                               step_inc,
	output logic                               cmp_phs_change
);

	import clk_ctrl_pkg::*;

	// First stage of the change flag
	logic cmp_phs_chg_m1;
	logic phase_differs;
	logic phase_above;

	// PLL restarts at phase 0 on either reset
	assign cmp_phs_rst = RST | cmp_phs_jtag_rst;

	assign phase_differs = (cmp_phase_target != cmp_phase_cur);
	assign phase_above   = (cmp_phase_target > cmp_phase_cur);

	// --------------------
	// Target lookup
	// --------------------

	always_ff @(posedge CLK40 or posedge cmp_phs_rst)
	begin
		if (cmp_phs_rst)
			cmp_phase_target <= '0;
		else
			cmp_phase_target <= cmp_phase_of(cmp_clk_phase);
	end

	// --------------------
	// Step requests
	// --------------------

	// Request only from a fully closed handshake
	// Retarget takes effect on the next request
	always_ff @(posedge CLK40 or posedge cmp_phs_rst)
	begin
		if (cmp_phs_rst)
		begin
			step_req      <= 1'b0;
			step_inc      <= 1'b0;
			cmp_phase_cur <= '0;
		end
		else
		begin
			if (!step_req && !step_ack)
			begin
				if (phase_differs)
				begin
					step_req <= 1'b1;
					// Direction frozen for this step
					step_inc <= phase_above;
				end
			end
			else if (step_req && step_ack)
			begin
				// PLL has moved one step
				if (step_inc)
					cmp_phase_cur <= cmp_phase_cur + 1'b1;
				else
					cmp_phase_cur <= cmp_phase_cur - 1'b1;
				step_req <= 1'b0;
			end
		end
	end

	// --------------------
	// Change flag
	// --------------------

	// Two registers so the flag settles behind the target
	always_ff @(posedge CLK40 or posedge cmp_phs_rst)
	begin
		if (cmp_phs_rst)
		begin
			cmp_phs_chg_m1 <= 1'b0;
			cmp_phs_change <= 1'b0;
		end
		else
		begin
			cmp_phs_chg_m1 <= phase_differs;
			cmp_phs_change <= cmp_phs_chg_m1;
		end
	end

endmodule

// File: dyn_phase_shift_fsm.sv
`timescale 1ns/1ps

module dyn_phase_shift_fsm
(
	input  logic                     CLK40,
	input  logic                     phs_rst,
	input  logic                     mmcm_locked,
	input  logic                     step_req,
	input  logic                     step_inc,
	input  logic                     ps_done,
	output logic                     step_ack,
	output logic                     psen,
	output logic                     phs_busy,
	output clk_ctrl_pkg::phs_state_t phs_state
);

	import clk_ctrl_pkg::*;

	phs_state_t state;
	// Direction seen when the request was taken
	logic       inc_q;

	assign phs_state = state;

	// --------------------
	// Step sequencer
	// --------------------

	always_ff @(posedge CLK40 or posedge phs_rst)
	begin
		if (phs_rst)
		begin
			state    <= ST_IDLE;
			inc_q    <= 1'b0;
			psen     <= 1'b0;
			step_ack <= 1'b0;
			phs_busy <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (step_req)
					begin
						inc_q <= step_inc;
						// Pulse right away when locked
						if (mmcm_locked)
						begin
							state    <= ST_PULSE;
							psen     <= 1'b1;
							phs_busy <= 1'b1;
						end
						else
							state <= ST_WAIT_LOCK;
					end
				end
				ST_WAIT_LOCK:
				begin
					// Direction moved before the pulse, take the request again
					if (step_inc != inc_q)
						state <= ST_IDLE;
					else if (mmcm_locked)
					begin
						state    <= ST_PULSE;
						psen     <= 1'b1;
						phs_busy <= 1'b1;
					end
				end
				ST_PULSE:
				begin
					// PSEN is one cycle wide
					psen  <= 1'b0;
					state <= ST_WAIT_DONE;
				end
				ST_WAIT_DONE:
				begin
					if (ps_done)
					begin
						step_ack <= 1'b1;
						state    <= ST_ACK;
					end
				end
				ST_ACK:
				begin
					// Close the four-phase handshake
					if (!step_req)
					begin
						step_ack <= 1'b0;
						phs_busy <= 1'b0;
						state    <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: clock_ctrl_top.sv
`timescale 1ns/1ps

module clock_ctrl_top
(
	input  logic                                CLK40,
	input  logic                                RST,
	input  logic                                resync,
	input  logic                                samp_clk_phs_chng,
	input  logic [clk_ctrl_pkg::SAMP_CODE_W-1:0] samp_clk_phase,
	input  logic [clk_ctrl_pkg::CMP_CODE_W-1:0]  cmp_clk_phase,
	input  logic                                cmp_phs_jtag_rst,
	input  logic                                mmcm_locked,
	input  logic                                ps_done,
	output logic                                lead_edge_resync,
	output logic                                cap_phase,
	output logic                                samp_mmcm_rst,
	output logic                                samp_in_sel,
	output logic                                dsr_resync,
	output logic                                cmp_phs_rst,
	output logic [clk_ctrl_pkg::PHASE_W-1:0]     cmp_phase_target,
	output logic [clk_ctrl_pkg::PHASE_W-1:0]     cmp_phase_cur,
	output logic                                step_req,
	output logic                                step_inc,
	output logic                                cmp_phs_change,
	output logic                                step_ack,
	output logic                                psen,
	output logic                                phs_busy,
	output clk_ctrl_pkg::phs_state_t            phs_state,
	output logic                                psincdec
);

	// Direction to the PLL phase port
	assign psincdec = step_inc;

	// Sampling clock side
	resync_ctrl u_resync_ctrl
	(
		.CLK40             (CLK40),
		.RST               (RST),
		.resync            (resync),
		.samp_clk_phs_chng (samp_clk_phs_chng),
		.samp_clk_phase    (samp_clk_phase),
		.lead_edge_resync  (lead_edge_resync),
		.cap_phase         (cap_phase),
		.samp_mmcm_rst     (samp_mmcm_rst),
		.samp_in_sel       (samp_in_sel),
		.dsr_resync        (dsr_resync)
	);

	// Comparator clock side
	cmp_phase_tracker u_cmp_phase_tracker
	(
		.CLK40            (CLK40),
		.RST              (RST),
		.cmp_phs_jtag_rst (cmp_phs_jtag_rst),
		.cmp_clk_phase    (cmp_clk_phase),
		.step_ack         (step_ack),
		.cmp_phs_rst      (cmp_phs_rst),
		.cmp_phase_target (cmp_phase_target),
		.cmp_phase_cur    (cmp_phase_cur),
		.step_req         (step_req),
		.step_inc         (step_inc),
		.cmp_phs_change   (cmp_phs_change)
	);

	// Sequencer shares the PLL phase reset
	dyn_phase_shift_fsm u_dyn_phase_shift_fsm
	(
		.CLK40       (CLK40),
		.phs_rst     (cmp_phs_rst),
		.mmcm_locked (mmcm_locked),
		.step_req    (step_req),
		.step_inc    (step_inc),
		.ps_done     (ps_done),
		.step_ack    (step_ack),
		.psen        (psen),
		.phs_busy    (phs_busy),
		.phs_state   (phs_state)
	);

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker
(
	input  logic                                 CLK40,
	input  logic                                 RST,
	input  logic                                 resync,
	input  logic                                 samp_clk_phs_chng,
	input  logic [clk_ctrl_pkg::SAMP_CODE_W-1:0] samp_clk_phase,
	input  logic [clk_ctrl_pkg::CMP_CODE_W-1:0]  cmp_clk_phase,
	input  logic                                 cmp_phs_jtag_rst,
	input  logic                                 mmcm_locked,
	input  logic                                 ps_done,
	input  logic                                 lead_edge_resync,
	input  logic                                 cap_phase,
	input  logic                                 samp_mmcm_rst,
	input  logic                                 samp_in_sel,
	input  logic                                 dsr_resync,
	input  logic                                 cmp_phs_rst,
	input  logic [clk_ctrl_pkg::PHASE_W-1:0]     cmp_phase_target,
	input  logic [clk_ctrl_pkg::PHASE_W-1:0]     cmp_phase_cur,
	input  logic                                 step_req,
	input  logic                                 step_inc,
	input  logic                                 cmp_phs_change,
	input  logic                                 step_ack,
	input  logic                                 psen,
	input  logic                                 phs_busy,
	input  clk_ctrl_pkg::phs_state_t             phs_state,
	input  logic                                 psincdec,
	input  int                                   pll_phase,
	output int                                   error_count,
	output int                                   check_count
);

	import clk_ctrl_pkg::*;

	localparam int HO_MIN = 3960;
	localparam int HO_MAX = 4040;

	// Reference model of the resync side
	logic                    ref_res_d1;
	logic                    ref_lead_d1;
	logic                    ref_cap;
	logic [RST_PIPE_LEN-1:0] ref_pipe;
	logic                    ref_c20;
	logic                    ref_sel;
	int                      rel_cnt;
	// Comparator side history
	logic [CMP_CODE_W-1:0]   code_q;
	logic                    tgt_valid;
	logic                    prev_cap;
	logic                    prev_dsr;
	logic                    prev_req;
	logic                    prev_ack;
	logic                    prev_inc;
	logic                    prev_done;
	logic [PHASE_W-1:0]      prev_tgt;
	// Direction owed by the current step
	logic                    dir_ref;
	logic                    busy_ref;
	logic                    diff_d1;
	logic                    diff_d2;
	phs_state_t              state_ref;
	int                      ho_len;
	int                      net_steps;
	int                      start_cur;

	initial
	begin
		error_count = 0;
		check_count = 0;
	end

	// Code to fine step, nearest of i*1344/31
	function automatic int cmp_phase_ref(input int code);
		return (code * 2 * CMP_STEPS_PER_CYCLE + 31) / 62;
	endfunction

	task automatic check_val(input string name, input int got, input int exp);
		check_count = check_count + 1;
		if (got != exp)
		begin
			error_count = error_count + 1;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report(input string what);
		error_count = error_count + 1;
		$display("Error at %0t: %s", $time, what);
	endtask

	// --------------------
	// Reference registers
	// --------------------

	always @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			ref_res_d1  <= 1'b0;
			ref_lead_d1 <= 1'b0;
			ref_cap     <= 1'b0;
			ref_pipe    <= '0;
			ref_c20     <= 1'b0;
			ref_sel     <= 1'b0;
			rel_cnt     <= 0;
		end
		else
		begin
			ref_res_d1  <= resync;
			ref_lead_d1 <= resync & ~ref_res_d1;
			// Two strobes after reset release
			ref_cap     <= (resync & ~ref_res_d1) | ref_lead_d1 | (rel_cnt < 2)
				| samp_clk_phs_chng;
			ref_pipe    <= {ref_pipe[RST_PIPE_LEN-2:0], ref_cap};
			if (rel_cnt < 2)
				rel_cnt <= rel_cnt + 1;
			ref_c20     <= (resync & ~ref_res_d1) ? 1'b0 : ~ref_c20;
			if (ref_cap)
				ref_sel <= ref_c20;
		end
	end

	always @(posedge CLK40 or posedge cmp_phs_rst)
	begin
		if (cmp_phs_rst)
			tgt_valid <= 1'b0;
		else
			tgt_valid <= 1'b1;
	end

	always @(posedge CLK40)
		code_q <= cmp_clk_phase;

	// --------------------
	// Comparisons at the falling edge
	// --------------------

	always @(negedge CLK40)
	begin
		// PLL phase reset follows either reset source
		check_val("cmp_phs_rst", int'(cmp_phs_rst), int'(RST | cmp_phs_jtag_rst));
		if (!RST)
		begin
			check_val("lead_edge_resync", int'(lead_edge_resync), int'(resync & ~ref_res_d1));
			check_val("cap_phase", int'(cap_phase), int'(ref_cap));
			check_val("samp_mmcm_rst", int'(samp_mmcm_rst), int'(|ref_pipe));
			check_val("samp_in_sel", int'(samp_in_sel), int'(samp_clk_phase[2] ^ ref_sel));
			if (prev_cap && !dsr_resync)
				report("dsr_resync did not rise after cap_phase");
			// Holdoff measured from the last capture
			if (cap_phase)
				ho_len = 0;
			else if (dsr_resync)
				ho_len = ho_len + 1;
			if (prev_dsr && !dsr_resync && (ho_len < HO_MIN || ho_len > HO_MAX))
				check_val("dsr_resync length", ho_len, 4000);
		end
		if (cmp_phs_rst)
		begin
			check_val("cmp_phase_cur", int'(cmp_phase_cur), 0);
			check_val("cmp_phs_change", int'(cmp_phs_change), 0);
			check_val("phs_busy", int'(phs_busy), 0);
			net_steps = 0;
			start_cur = 0;
			busy_ref  = 1'b0;
			diff_d1   = 1'b0;
			diff_d2   = 1'b0;
		end
		else
		begin
			if (tgt_valid)
				check_val("cmp_phase_target", int'(cmp_phase_target),
					cmp_phase_ref(int'(code_q)));
			// Change flag trails the difference by two cycles
			check_val("cmp_phs_change", int'(cmp_phs_change), int'(diff_d2));
			diff_d2 = diff_d1;
			diff_d1 = (cmp_phase_target != cmp_phase_cur);
			if (psen && !mmcm_locked)
				report("psen pulsed while mmcm_locked was low");
			if (psen)
			begin
				check_val("psincdec", int'(psincdec), int'(dir_ref));
				net_steps = net_steps + (psincdec ? 1 : -1);
			end
			// Four-phase order
			if (step_req && !prev_req)
			begin
				if (step_ack)
					report("step_req rose while step_ack was high");
				// Target as the tracker saw it before this edge
				dir_ref = (prev_tgt > cmp_phase_cur);
				check_val("step_inc", int'(step_inc), int'(dir_ref));
			end
			if (step_req && prev_req && step_inc != prev_inc)
				report("step_inc changed while step_req was high");
			if (step_ack && !prev_ack && (!step_req || !prev_done))
				report("step_ack rose without step_req and ps_done");
			if (!step_req && prev_req && !prev_ack)
				report("step_req fell before step_ack rose");
			if (!step_ack && prev_ack && step_req)
				report("step_ack fell while step_req was high");
			if (step_ack && !step_req)
				check_val("pll phase count", pll_phase, int'(cmp_phase_cur));
			// Busy from the pulse until the acknowledge drops
			if (psen)
				busy_ref = 1'b1;
			else if (prev_ack && !step_ack)
				busy_ref = 1'b0;
			check_val("phs_busy", int'(phs_busy), int'(busy_ref));
			if (psen)
				state_ref = ST_PULSE;
			else if (step_ack)
				state_ref = ST_ACK;
			else if (busy_ref)
				state_ref = ST_WAIT_DONE;
			else if (step_req && prev_req)
				state_ref = ST_WAIT_LOCK;
			else
				state_ref = ST_IDLE;
			check_val("phs_state", int'(phs_state), int'(state_ref));
			// Pulse count over one settled phase change
			if (!step_req && !step_ack && cmp_phase_cur == cmp_phase_target
				&& int'(cmp_phase_cur) != start_cur)
			begin
				check_val("psen count", net_steps, int'(cmp_phase_cur) - start_cur);
				start_cur = int'(cmp_phase_cur);
				net_steps = 0;
			end
		end
		prev_cap  = cap_phase;
		prev_dsr  = dsr_resync;
		prev_req  = step_req;
		prev_ack  = step_ack;
		prev_inc  = step_inc;
		prev_done = ps_done;
		prev_tgt  = cmp_phase_target;
	end

endmodule

// File: tb_clock_ctrl.sv
`timescale 1ns/1ps

module tb_clock_ctrl;

	import clk_ctrl_pkg::*;

	// 8 phase changes, retarget and JTAG reset, plus the holdoffs
	localparam int CYCLE_LIMIT = 200000;

	logic                   CLK40;
	logic                   RST;
	logic                   resync;
	logic                   samp_clk_phs_chng;
	logic [SAMP_CODE_W-1:0] samp_clk_phase;
	logic [CMP_CODE_W-1:0]  cmp_clk_phase;
	logic                   cmp_phs_jtag_rst;
	logic                   mmcm_locked;
	logic                   ps_done;
	logic                   lead_edge_resync;
	logic                   cap_phase;
	logic                   samp_mmcm_rst;
	logic                   samp_in_sel;
	logic                   dsr_resync;
	logic                   cmp_phs_rst;
	logic [PHASE_W-1:0]     cmp_phase_target;
	logic [PHASE_W-1:0]     cmp_phase_cur;
	logic                   step_req;
	logic                   step_inc;
	logic                   cmp_phs_change;
	logic                   step_ack;
	logic                   psen;
	logic                   phs_busy;
	phs_state_t             phs_state;
	logic                   psincdec;
	// PLL model state
	int                     pll_phase;
	int                     done_cnt;
	int                     lock_cnt;
	// Phase port as it stood before the edge
	logic                   rst_seen;
	logic                   psen_seen;
	logic                   inc_seen;
	logic [31:0]            pll_seed;
	logic [31:0]            stim_seed;
	int                     cycle_cnt;
	int                     error_count;
	int                     check_count;

	clock_ctrl_top uut
	(
		.CLK40             (CLK40),
		.RST               (RST),
		.resync            (resync),
		.samp_clk_phs_chng (samp_clk_phs_chng),
		.samp_clk_phase    (samp_clk_phase),
		.cmp_clk_phase     (cmp_clk_phase),
		.cmp_phs_jtag_rst  (cmp_phs_jtag_rst),
		.mmcm_locked       (mmcm_locked),
		.ps_done           (ps_done),
		.lead_edge_resync  (lead_edge_resync),
		.cap_phase         (cap_phase),
		.samp_mmcm_rst     (samp_mmcm_rst),
		.samp_in_sel       (samp_in_sel),
		.dsr_resync        (dsr_resync),
		.cmp_phs_rst       (cmp_phs_rst),
		.cmp_phase_target  (cmp_phase_target),
		.cmp_phase_cur     (cmp_phase_cur),
		.step_req          (step_req),
		.step_inc          (step_inc),
		.cmp_phs_change    (cmp_phs_change),
		.step_ack          (step_ack),
		.psen              (psen),
		.phs_busy          (phs_busy),
		.phs_state         (phs_state),
		.psincdec          (psincdec)
	);

	tb_checker chk
	(
		.CLK40             (CLK40),
		.RST               (RST),
		.resync            (resync),
		.samp_clk_phs_chng (samp_clk_phs_chng),
		.samp_clk_phase    (samp_clk_phase),
		.cmp_clk_phase     (cmp_clk_phase),
		.cmp_phs_jtag_rst  (cmp_phs_jtag_rst),
		.mmcm_locked       (mmcm_locked),
		.ps_done           (ps_done),
		.lead_edge_resync  (lead_edge_resync),
		.cap_phase         (cap_phase),
		.samp_mmcm_rst     (samp_mmcm_rst),
		.samp_in_sel       (samp_in_sel),
		.dsr_resync        (dsr_resync),
		.cmp_phs_rst       (cmp_phs_rst),
		.cmp_phase_target  (cmp_phase_target),
		.cmp_phase_cur     (cmp_phase_cur),
		.step_req          (step_req),
		.step_inc          (step_inc),
		.cmp_phs_change    (cmp_phs_change),
		.step_ack          (step_ack),
		.psen              (psen),
		.phs_busy          (phs_busy),
		.phs_state         (phs_state),
		.psincdec          (psincdec),
		.pll_phase         (pll_phase),
		.error_count       (error_count),
		.check_count       (check_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial
		CLK40 = 1'b0;
	always
		#10 CLK40 = ~CLK40;

	// --------------------
	// PLL phase port model
	// --------------------

	always @(posedge CLK40)
	begin
		rst_seen  = cmp_phs_rst;
		psen_seen = psen;
		inc_seen  = psincdec;
		#2;
		if (rst_seen)
		begin
			pll_phase   = 0;
			done_cnt    = 0;
			ps_done     = 1'b0;
			mmcm_locked = 1'b0;
			lock_cnt    = 20;
		end
		else
		begin
			ps_done = 1'b0;
			// Relock 20 cycles after reset
			if (lock_cnt > 0)
				lock_cnt = lock_cnt - 1;
			else
				mmcm_locked = 1'b1;
			if (psen_seen)
			begin
				if (inc_seen)
					pll_phase = pll_phase + 1;
				else
					pll_phase = pll_phase - 1;
				pll_seed = lcg_next(pll_seed);
				// Done 4 to 15 cycles after the pulse
				done_cnt = 3 + int'(pll_seed[19:16]) % 12;
			end
			else if (done_cnt > 0)
			begin
				done_cnt = done_cnt - 1;
				if (done_cnt == 0)
					ps_done = 1'b1;
			end
		end
	end

	// Run limit
	always @(posedge CLK40)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	// --------------------
	// Stimulus tasks
	// --------------------

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK40);
		#2;
	endtask

	task automatic pulse_resync();
		resync = 1'b1;
		wait_cycles(3);
		resync = 1'b0;
		wait_cycles(1);
	endtask

	task automatic wait_holdoff_end();
		@(negedge CLK40);
		while (dsr_resync)
			@(negedge CLK40);
		wait_cycles(2);
	endtask

	task automatic wait_converged();
		// Target must settle first
		wait_cycles(3);
		@(negedge CLK40);
		while (step_req || step_ack || (cmp_phase_cur != cmp_phase_target))
			@(negedge CLK40);
		wait_cycles(4);
	endtask

	task automatic new_code();
		stim_seed     = lcg_next(stim_seed);
		cmp_clk_phase = stim_seed[20:16];
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial
	begin
		RST               = 1'b1;
		resync            = 1'b0;
		samp_clk_phs_chng = 1'b0;
		samp_clk_phase    = '0;
		cmp_clk_phase     = '0;
		cmp_phs_jtag_rst  = 1'b0;
		mmcm_locked       = 1'b0;
		ps_done           = 1'b0;
		pll_phase         = 0;
		done_cnt          = 0;
		lock_cnt          = 20;
		pll_seed          = 32'heac9;
		stim_seed         = 32'heac9;
		cycle_cnt         = 0;
		wait_cycles(16);
		RST = 1'b0;
		// Post-reset capture and holdoff
		wait_cycles(4);
		wait_holdoff_end();
		// Resync, then a second one to restart the holdoff
		samp_clk_phase = 3'b100;
		pulse_resync();
		wait_cycles(1000);
		pulse_resync();
		wait_holdoff_end();
		// Sampling phase change
		stim_seed         = lcg_next(stim_seed);
		samp_clk_phase    = stim_seed[18:16];
		samp_clk_phs_chng = 1'b1;
		wait_cycles(1);
		samp_clk_phs_chng = 1'b0;
		wait_holdoff_end();
		// Random comparator phase codes
		repeat (6)
		begin
			new_code();
			wait_converged();
		end
		// Retarget while stepping
		new_code();
		wait_cycles(200);
		new_code();
		wait_converged();
		// JTAG phase reset in the middle of stepping
		new_code();
		wait_cycles(100);
		cmp_phs_jtag_rst = 1'b1;
		wait_cycles(3);
		cmp_phs_jtag_rst = 1'b0;
		wait_converged();
		new_code();
		wait_converged();
		wait_cycles(10);
		$display("Errors: %0d of %0d checks", error_count, check_count);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: list.f
clk_ctrl_pkg.sv
resync_ctrl.sv
cmp_phase_tracker.sv
dyn_phase_shift_fsm.sv
clock_ctrl_top.sv
tb_checker.sv
tb_clock_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the clock control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_clock_ctrl -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

# Pass only if the pass line is present
grep -qx "test passed" sim.log
